/* build.f */
source/fetch_pkg.sv
source/align_instructions.sv
source/l0_line_buffer.sv
source/fetch.sv
source/fetch_frontend.sv
tb/fetch_frontend_chk.sv
tb/fetch_frontend_tb.sv

/* Makefile */
SOURCES := $(wildcard source/*.sv tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vfetch_frontend_tb: build.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module fetch_frontend_tb -f build.f

run: obj_dir/Vfetch_frontend_tb
	obj_dir/Vfetch_frontend_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* tb/fetch_frontend_tb.sv */
`timescale 1ns/1ns

module fetch_frontend_tb;

    import fetch_pkg::*;

    localparam int  SSW              = 4;
    localparam int  LINE_BYTES       = 64;
    localparam int  L0_ENTRIES       = 4;
    localparam int  OFFSET_BITS      = $clog2(LINE_BYTES);
    localparam int  INDEX_BITS       = $clog2(L0_ENTRIES);
    localparam int  RANDOM_PCS       = 40;
    localparam int  DIRECTED_FETCHES = 10;
    localparam int  FETCH_CYCLES     = 16;  // one fetch with a 6 cycle miss and the handoff
    localparam int  TIMEOUT_NS       =
        ((DIRECTED_FETCHES + RANDOM_PCS) * FETCH_CYCLES + 10) * 20 + 2000;
    localparam pc_t LINE_MASK        = ~pc_t'(LINE_BYTES - 1);

    typedef instr_t [SSW-1:0] slots_t;

    logic                    clk_in = 1'b0;
    logic                    rst_N_in;
    logic                    flush_in;
    fetch_req_t              bp_req;
    logic                    l1i_valid = 1'b0;
    pc_t                     l1i_addr = '0;
    logic [LINE_BYTES*8-1:0] l1i_line = '0;
    l1i_req_t                l1i_req;
    logic                    fetch_valid;
    logic                    fetch_ready;
    slots_t                  fetched_instrs;
    pc_t                     next_pc;

    int                    req_count = 0;   // line requests seen by the L1I model
    int                    countdown = 0;
    int                    next_delay = 2;
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    pc_t                   last_req_addr = '0;
    pc_t                   shadow_line [L0_ENTRIES];   // testbench copy of the L0 tags
    logic [L0_ENTRIES-1:0] shadow_valid;

    always #10 clk_in = ~clk_in;

    fetch_frontend #(
        .SUPER_SCALAR_WIDTH (SSW),
        .LINE_BYTES         (LINE_BYTES),
        .L0_ENTRIES         (L0_ENTRIES)
    ) u_dut (
        .clk_in         (clk_in),
        .rst_N_in       (rst_N_in),
        .flush_in       (flush_in),
        .bp_req         (bp_req),
        .l1i_valid      (l1i_valid),
        .l1i_addr       (l1i_addr),
        .l1i_line       (l1i_line),
        .l1i_req        (l1i_req),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready),
        .fetched_instrs (fetched_instrs),
        .next_pc        (next_pc)
    );

    bind fetch fetch_frontend_chk u_chk (
        .clk_in      (clk_in),
        .rst_N_in    (rst_N_in),
        .flush_in    (flush_in),
        .l1i_req     (l1i_req),
        .l1i_valid   (l1i_valid),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready)
    );

    function automatic logic [7:0] mem_byte(pc_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic logic [LINE_BYTES*8-1:0] line_at(pc_t base);
        logic [LINE_BYTES*8-1:0] l;
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[i*8 +: 8] = mem_byte(base + pc_t'(i));
        end
        return l;
    endfunction

    // slot i holds the little endian bytes offset+4i up to offset+4i+3 or a nop off the line
    function automatic slots_t expect_instrs(pc_t pc);
        slots_t s;
        pc_t    base;
        int     b;
        base = pc & LINE_MASK;
        for (int i = 0; i < SSW; i++) begin
            b = int'(pc[OFFSET_BITS-1:0]) + 4 * i;
            if (b + 3 < LINE_BYTES) begin
                s[i] = {mem_byte(base + pc_t'(b + 3)), mem_byte(base + pc_t'(b + 2)),
                        mem_byte(base + pc_t'(b + 1)), mem_byte(base + pc_t'(b))};
            end else begin
                s[i] = FETCH_NOP;
            end
        end
        return s;
    endfunction

    function automatic logic predict_miss(pc_t pc);
        logic [INDEX_BITS-1:0] idx;
        idx = pc[OFFSET_BITS +: INDEX_BITS];
        return !(shadow_valid[idx] && shadow_line[idx] == (pc & LINE_MASK));
    endfunction

    // L1I model that answers the request pulse after next_delay cycles
    always @(posedge clk_in) begin
        l1i_valid <= 1'b0;
        if (rst_N_in) begin
            countdown    <= 0;
            shadow_valid <= '0;
        end else if (l1i_req.valid) begin
            req_count     <= req_count + 1;
            last_req_addr <= l1i_req.addr;
            countdown     <= next_delay;
        end else if (countdown == 1) begin
            countdown <= 0;
            l1i_valid <= 1'b1;
            l1i_addr  <= last_req_addr;
            l1i_line  <= line_at(last_req_addr);
            // every response lands in L0 whether flushed or not
            shadow_valid[last_req_addr[OFFSET_BITS +: INDEX_BITS]] <= 1'b1;
            shadow_line[last_req_addr[OFFSET_BITS +: INDEX_BITS]]  <= last_req_addr;
        end else if (countdown > 1) begin
            countdown <= countdown - 1;
        end
    end

    task automatic check_instrs(string what, slots_t exp, slots_t act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic check_pc(string what, pc_t exp, pc_t act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %b actual %b", what, exp, act);
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // waits until the front end is ready, then holds the pc for the accepting edge
    task automatic offer(pc_t pc);
        @(negedge clk_in);
        while (!fetch_ready) begin
            @(negedge clk_in);
        end
        next_delay = 2 + int'($urandom % 5);
        @(posedge clk_in);
        bp_req <= '{valid: 1'b1, pc: pc};
        @(posedge clk_in);                  // accepted here
        bp_req.valid <= 1'b0;
    endtask

    task automatic fetch_pc(string name, pc_t pc, logic exp_miss);
        int reqs_before;
        int waited;
        reqs_before = req_count;
        offer(pc);
        @(negedge clk_in);
        if (exp_miss) begin
            check_bit({name, " fetch_ready"}, 1'b0, fetch_ready);
        end
        waited = 0;
        while (!fetch_valid && waited < FETCH_CYCLES) begin
            @(negedge clk_in);
            waited++;
        end
        if (!fetch_valid) begin
            errors++;
            $display("%s: fetch_valid did not come within %0d cycles", name, waited);
        end
        check_bit({name, " l1i request"}, exp_miss, req_count != reqs_before);
        if (req_count - reqs_before > 1) begin
            errors++;
            $display("%s: more than one L1I request for a single pc", name);
        end
        if (exp_miss) begin
            check_pc({name, " l1i addr"}, pc & LINE_MASK, last_req_addr);
        end
        check_instrs({name, " instrs"}, expect_instrs(pc), fetched_instrs);
        check_pc({name, " next_pc"}, pc, next_pc);
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        @(posedge clk_in);
        @(negedge clk_in);
        check_bit("reset fetch_valid", 1'b0, fetch_valid);
        check_bit("reset l1i_req.valid", 1'b0, l1i_req.valid);
        check_bit("reset fetch_ready", 1'b1, fetch_ready);
        report_test("reset", e);
    endtask

    task automatic test_miss_hit();
        int e;
        e = errors;
        fetch_pc("miss_hit first", 64'h1008, 1'b1);
        fetch_pc("miss_hit second", 64'h1014, 1'b0);
        report_test("miss_hit", e);
    endtask

    task automatic test_line_end();
        int e;
        e = errors;
        fetch_pc("line_end 58", 64'h20BA, 1'b1);     // one word and then nops
        fetch_pc("line_end 60", 64'h20BC, 1'b0);
        report_test("line_end", e);
    endtask

    task automatic test_flush();
        int e;
        int waited;
        int reqs_before;
        e = errors;
        reqs_before = req_count;
        offer(64'h2444);
        flush_in <= 1'b1;
        @(posedge clk_in);
        flush_in <= 1'b0;
        waited = 0;
        @(negedge clk_in);
        while (!fetch_ready && waited < FETCH_CYCLES) begin
            check_bit("flush fetch_valid", 1'b0, fetch_valid);
            @(negedge clk_in);
            waited++;
        end
        if (!fetch_ready) begin
            errors++;
            $display("flush: fetch_ready stayed low after the discarded response");
        end
        repeat (2) begin
            check_bit("flush late fetch_valid", 1'b0, fetch_valid);
            @(negedge clk_in);
        end
        check_bit("flush l1i request", 1'b1, req_count != reqs_before);
        fetch_pc("flush refetch", 64'h2450, 1'b0);   // line was still written
        report_test("flush", e);
    endtask

    task automatic test_conflict();
        int e;
        e = errors;
        fetch_pc("conflict a", 64'h3004, 1'b1);
        fetch_pc("conflict b", 64'h3108, 1'b1);      // same index as a
        fetch_pc("conflict a again", 64'h300C, 1'b1);
        report_test("conflict", e);
    endtask

    task automatic test_random();
        int  e;
        pc_t pc;
        e = errors;
        for (int n = 0; n < RANDOM_PCS; n++) begin
            pc = 64'h4000 + pc_t'($urandom % (8 * LINE_BYTES));  // eight lines on four sets
            fetch_pc($sformatf("random %0d", n), pc, predict_miss(pc));
        end
        report_test("random", e);
    endtask

    initial begin
        void'($urandom(38368));
        rst_N_in = 1'b1;
        flush_in = 1'b0;
        bp_req   = '0;
        repeat (10) @(posedge clk_in);
        rst_N_in <= 1'b0;
        test_reset();
        test_miss_hit();
        test_line_end();
        test_flush();
        test_conflict();
        test_random();
        $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* tb/fetch_frontend_chk.sv */
`timescale 1ns/1ns

module fetch_frontend_chk (
    input logic                clk_in,
    input logic                rst_N_in,
    input logic                flush_in,
    input fetch_pkg::l1i_req_t l1i_req,
    input logic                l1i_valid,
    input logic                fetch_valid,
    input logic                fetch_ready
);

    logic outstanding_q;    // a line request is out at the L1I

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            outstanding_q <= 1'b0;
        end else if (l1i_req.valid) begin
            outstanding_q <= 1'b1;
        end else if (l1i_valid) begin
            outstanding_q <= 1'b0;       // response ends the miss
        end
    end

    a_single_request: assert property (@(posedge clk_in) disable iff (rst_N_in)
        l1i_req.valid |-> !outstanding_q)
        else $error("l1i request raised while a miss is outstanding");

    // ready stays low from the request pulse until the response
    a_ready_low: assert property (@(posedge clk_in) disable iff (rst_N_in)
        (l1i_req.valid || outstanding_q) |-> !fetch_ready)
        else $error("fetch_ready high while a miss is outstanding");

    a_flush_quiet: assert property (@(posedge clk_in) disable iff (rst_N_in)
        flush_in |=> !fetch_valid)
        else $error("fetch_valid high the cycle after a flush");

endmodule

/* source/fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend #(
    parameter int SUPER_SCALAR_WIDTH = 4,
    parameter int LINE_BYTES         = 64,
    parameter int L0_ENTRIES         = 4
) (
    input  logic                                       clk_in,
    input  logic                                       rst_N_in,
    input  logic                                       flush_in,
    input  fetch_pkg::fetch_req_t                      bp_req,
    input  logic                                       l1i_valid,
    input  fetch_pkg::pc_t                             l1i_addr,
    input  logic [LINE_BYTES*8-1:0]                    l1i_line,
    output fetch_pkg::l1i_req_t                        l1i_req,
    output logic                                       fetch_valid,
    output logic                                       fetch_ready,
    output fetch_pkg::instr_t [SUPER_SCALAR_WIDTH-1:0] fetched_instrs,
    output fetch_pkg::pc_t                             next_pc
);

    import fetch_pkg::*;

    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

    logic                             l0_hit;
    logic [LINE_BYTES*8-1:0]          l0_line;
    instr_t [SUPER_SCALAR_WIDTH-1:0] l0_instrs;
    instr_t [SUPER_SCALAR_WIDTH-1:0] l1i_instrs;
    pc_t                              miss_pc;
    logic                             fill_valid;

    l0_line_buffer #(
        .LINE_BYTES (LINE_BYTES),
        .L0_ENTRIES (L0_ENTRIES)
    ) u_l0 (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .lookup_pc  (bp_req.pc),
        .hit        (l0_hit),
        .hit_line   (l0_line),
        .fill_valid (fill_valid),
        .fill_addr  (l1i_addr),
        .fill_line  (l1i_line)
    );

    // hit path aligns at the predicted pc
    align_instructions #(
        .SUPER_SCALAR_WIDTH (SUPER_SCALAR_WIDTH),
        .LINE_BYTES         (LINE_BYTES)
    ) u_l0_align (
        .offset (bp_req.pc[OFFSET_BITS-1:0]),
        .line   (l0_line),
        .instrs (l0_instrs)
    );

    // miss path aligns the returning line at the held pc
    align_instructions #(
        .SUPER_SCALAR_WIDTH (SUPER_SCALAR_WIDTH),
        .LINE_BYTES         (LINE_BYTES)
    ) u_l1i_align (
        .offset (miss_pc[OFFSET_BITS-1:0]),
        .line   (l1i_line),
        .instrs (l1i_instrs)
    );

    fetch #(
        .SUPER_SCALAR_WIDTH (SUPER_SCALAR_WIDTH),
        .LINE_BYTES         (LINE_BYTES)
    ) u_fetch (
        .clk_in         (clk_in),
        .rst_N_in       (rst_N_in),
        .flush_in       (flush_in),
        .bp_req         (bp_req),
        .l0_hit         (l0_hit),
        .l0_instrs      (l0_instrs),
        .l1i_instrs     (l1i_instrs),
        .l1i_valid      (l1i_valid),
        .l1i_req        (l1i_req),
        .miss_pc        (miss_pc),
        .fill_valid     (fill_valid),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready),
        .fetched_instrs (fetched_instrs),
        .next_pc        (next_pc)
    );

endmodule

/* source/fetch.sv */
`timescale 1ns/1ns

module fetch #(
    parameter int SUPER_SCALAR_WIDTH = 4,
    parameter int LINE_BYTES         = 64
) (
    input  logic                                       clk_in,
    input  logic                                       rst_N_in,
    input  logic                                       flush_in,     // misprediction
    input  fetch_pkg::fetch_req_t                      bp_req,
    input  logic                                       l0_hit,
    input  fetch_pkg::instr_t [SUPER_SCALAR_WIDTH-1:0] l0_instrs,
    input  fetch_pkg::instr_t [SUPER_SCALAR_WIDTH-1:0] l1i_instrs,
    input  logic                                       l1i_valid,
    output fetch_pkg::l1i_req_t                        l1i_req,
    output fetch_pkg::pc_t                             miss_pc,      // pc waiting on the L1I
    output logic                                       fill_valid,
    output logic                                       fetch_valid,
    output logic                                       fetch_ready,
    output fetch_pkg::instr_t [SUPER_SCALAR_WIDTH-1:0] fetched_instrs,
    output fetch_pkg::pc_t                             next_pc
);

    import fetch_pkg::*;

    localparam pc_t LINE_MASK = ~pc_t'(LINE_BYTES - 1);

    // WAIT has a miss out and delivers on its return
    // DISCARD has a miss out after a flush and only fills L0
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DISCARD
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   req_valid_q;
    logic   accept;
    logic   take_hit;
    logic   take_miss;
    logic   deliver;

    assign accept    = bp_req.valid && fetch_ready && !flush_in;
    assign take_hit  = accept && l0_hit;
    assign take_miss = accept && !l0_hit;
    assign deliver   = (state_q == WAIT) && l1i_valid && !flush_in;

    assign fetch_ready = (state_q == IDLE);            // predictor holds its pc otherwise
    assign fill_valid  = l1i_valid && (state_q != IDLE);
    assign l1i_req     = '{valid: req_valid_q, addr: miss_pc & LINE_MASK};

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take_miss) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                // a response in the flush cycle still ends the miss
                if (l1i_valid) begin
                    state_d = IDLE;
                end else if (flush_in) begin
                    state_d = DISCARD;
                end
            end
            DISCARD: begin
                if (l1i_valid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            state_q     <= IDLE;
            req_valid_q <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_valid_q <= take_miss;                  // single cycle pulse
            fetch_valid <= take_hit || deliver;
        end
    end

    // payload toward decode and the held miss pc
    always_ff @(posedge clk_in) begin
        if (take_miss) begin
            miss_pc <= bp_req.pc;
        end
        if (take_hit) begin
            fetched_instrs <= l0_instrs;
            next_pc        <= bp_req.pc;
        end else if (deliver) begin
            fetched_instrs <= l1i_instrs;
            next_pc        <= miss_pc;
        end
    end

endmodule

/* source/l0_line_buffer.sv */
`timescale 1ns/1ns

module l0_line_buffer #(
    parameter int LINE_BYTES = 64,
    parameter int L0_ENTRIES = 4
) (
    input  logic                    clk_in,
    input  logic                    rst_N_in,
    input  fetch_pkg::pc_t          lookup_pc,
    output logic                    hit,
    output logic [LINE_BYTES*8-1:0] hit_line,
    input  logic                    fill_valid,
    input  fetch_pkg::pc_t          fill_addr,  // line address of the returning line
    input  logic [LINE_BYTES*8-1:0] fill_line
);

    import fetch_pkg::*;

    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int INDEX_BITS  = $clog2(L0_ENTRIES);
    localparam int TAG_BITS    = PC_WIDTH - OFFSET_BITS - INDEX_BITS;

    // one line slot with its tag kept next to the data
    typedef struct packed {
        logic [TAG_BITS-1:0]     tag;
        logic [LINE_BYTES*8-1:0] data;
    } entry_t;

    entry_t                entries_q [L0_ENTRIES];
    logic [L0_ENTRIES-1:0] valid_q;

    logic [INDEX_BITS-1:0] lookup_idx;
    logic [TAG_BITS-1:0]   lookup_tag;
    logic [INDEX_BITS-1:0] fill_idx;
    logic [TAG_BITS-1:0]   fill_tag;
    entry_t                lookup_entry;

    // index is the low line number bits, tag is whatever is left above
    assign lookup_idx = lookup_pc[OFFSET_BITS +: INDEX_BITS];
    assign lookup_tag = lookup_pc[PC_WIDTH-1 -: TAG_BITS];
    assign fill_idx   = fill_addr[OFFSET_BITS +: INDEX_BITS];
    assign fill_tag   = fill_addr[PC_WIDTH-1 -: TAG_BITS];

    // combinational read
    assign lookup_entry = entries_q[lookup_idx];
    assign hit          = valid_q[lookup_idx] && (lookup_entry.tag == lookup_tag);
    assign hit_line     = lookup_entry.data;

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            valid_q <= '0;                      // buffer starts empty
        end else if (fill_valid) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // fill overwrites whatever sits at that index
    always_ff @(posedge clk_in) begin
        if (fill_valid) begin
            entries_q[fill_idx] <= '{tag: fill_tag, data: fill_line};
        end
    end

endmodule

/* source/align_instructions.sv */
`timescale 1ns/1ns

module align_instructions #(
    parameter int SUPER_SCALAR_WIDTH = 4,
    parameter int LINE_BYTES         = 64
) (
    input  logic [$clog2(LINE_BYTES)-1:0]               offset, // byte offset of the pc in the line
    input  logic [LINE_BYTES*8-1:0]                     line,   // byte 0 in the low bits
    output fetch_pkg::instr_t [SUPER_SCALAR_WIDTH-1:0] instrs
);

    import fetch_pkg::*;

    // slot i is the little endian word at offset + 4*i
    // a slot that would cross the line end gets a nop
    always_comb begin
        int b;
        for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
            b = int'(offset) + INSTR_BYTES * i;
            if (b + INSTR_BYTES - 1 < LINE_BYTES) begin
                instrs[i] = line[b*8 +: INSTR_WIDTH];
            end else begin
                instrs[i] = FETCH_NOP;
            end
        end
    end

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

    // instruction word size for fixed length instructions only
    localparam int INSTR_WIDTH = 32;
    localparam int INSTR_BYTES = INSTR_WIDTH / 8;

    // byte addressed pc
    localparam int PC_WIDTH = 64;

    typedef logic [INSTR_WIDTH-1:0] instr_t;
    typedef logic [PC_WIDTH-1:0]    pc_t;

    // filler for slots that run past the end of a line
    localparam instr_t FETCH_NOP = 32'hD503201F;

    // predicted pc offered by the branch predictor
    typedef struct packed {
        logic valid;
        pc_t  pc;
    } fetch_req_t;

    // line request toward the L1I with a line aligned addr
    typedef struct packed {
        logic valid;
        pc_t  addr;
    } l1i_req_t;

endpackage
